// ==== design/obi_xbar_settings.svh ====
`ifndef OBI_XBAR_SETTINGS_SVH
`define OBI_XBAR_SETTINGS_SVH

// OBI side widths, one tag bit above the 32 data bits
`define OBI_DW  33
`define OBI_AW  32
`define OBI_BEW 4

// AXI data path carries no tag bit
`define AXI_DW  32

// master 0 is the data port and wins arbitration
`define N_MSTR  2
`define N_SLV   3

// ========================================
// address windows, start inclusive, end exclusive
// ========================================
`define IROM_START 32'h2000_0000
`define IROM_END   32'h2004_0000
`define DRAM_START 32'h200F_0000
`define DRAM_END   32'h2010_0000

`endif

// ==== design/obi_xbar_pkg.sv ====
package obi_xbar_pkg;

  // bit position of each slave in the one-hot request vectors
  typedef enum logic [1:0] {
    SLV_IROM = 2'd0,
    SLV_DRAM = 2'd1,
    SLV_AXI  = 2'd2
  } slv_sel_e;

  // single-beat AXI bridge
  typedef enum logic [1:0] {
    AXI_IDLE,
    AXI_ACC,
    AXI_RESP
  } axi_state_e;

endpackage

// ==== design/obi_mstr_port.sv ====
`timescale 1ns/1ps
`include "obi_xbar_settings.svh"

module obi_mstr_port (
  input  logic                             clk_i,
  input  logic                             rstn_i,

  input  logic                             req_i,
  output logic                             gnt_o,
  input  logic [`OBI_AW-1:0]               addr_i,
  output logic [`OBI_DW-1:0]               rdata_o,
  output logic                             rvalid_o,
  output logic                             err_o,

  output logic [`N_SLV-1:0]                slv_req_o,
  input  logic [`N_SLV-1:0]                slv_gnt_i,
  input  logic [`N_SLV-1:0][`OBI_DW-1:0]   slv_rdata_i,
  input  logic [`N_SLV-1:0]                slv_rvalid_i,
  input  logic [`N_SLV-1:0]                slv_err_i
);

  obi_xbar_pkg::slv_sel_e sel;

  logic [`N_SLV-1:0] slv_dec;
  logic [`N_SLV-1:0] pending_q;
  logic              rvalid_done;
  logic              req_ok;

  // ========================================
  // address decode
  // ========================================

  always_comb begin
    if (addr_i >= `IROM_START && addr_i < `IROM_END) begin
      sel = obi_xbar_pkg::SLV_IROM;
    end else if (addr_i >= `DRAM_START && addr_i < `DRAM_END) begin
      sel = obi_xbar_pkg::SLV_DRAM;
    end else begin
      // anything unmapped goes out over AXI
      sel = obi_xbar_pkg::SLV_AXI;
    end
  end

  assign slv_dec = req_i ? (`N_SLV'(1) << sel) : '0;

  // ========================================
  // switch hold
  // ========================================

  // a different slave waits for the pending response, same slave may pipeline
  assign rvalid_done = |(pending_q & slv_rvalid_i);
  assign req_ok      = (pending_q == '0) || (pending_q == slv_dec) || rvalid_done;
  assign slv_req_o   = req_ok ? slv_dec : '0;

  assign gnt_o = |(slv_gnt_i & slv_req_o);

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      pending_q <= '0;
    end else if (gnt_o) begin
      pending_q <= slv_req_o;
    end else if (rvalid_done) begin
      pending_q <= '0;
    end
  end

  // ========================================
  // response select
  // ========================================

  always_comb begin
    rdata_o = '0;
    for (int i = 0; i < `N_SLV; i++) begin
      if (pending_q[i]) begin
        rdata_o = slv_rdata_i[i];
      end
    end
  end

  assign rvalid_o = rvalid_done;
  assign err_o    = |(pending_q & slv_rvalid_i & slv_err_i);

  // at most one slave sees this master at a time
  a_req_onehot: assert property (
    @(posedge clk_i) disable iff (!rstn_i) $onehot0(slv_req_o)
  ) else $error("master port drives more than one slave request");

endmodule

// ==== design/obi_mem_arb.sv ====
`timescale 1ns/1ps
`include "obi_xbar_settings.svh"

module obi_mem_arb (
  input  logic                              clk_i,
  input  logic                              rstn_i,

  input  logic [`N_MSTR-1:0]                req_i,
  output logic [`N_MSTR-1:0]                gnt_o,
  input  logic [`N_MSTR-1:0][`OBI_AW-1:0]   addr_i,
  input  logic [`N_MSTR-1:0][`OBI_BEW-1:0]  be_i,
  input  logic [`N_MSTR-1:0][`OBI_DW-1:0]   wdata_i,
  input  logic [`N_MSTR-1:0]                we_i,
  output logic [`OBI_DW-1:0]                rdata_o,
  output logic                              rvalid_o,
  output logic                              err_o,

  output logic                              mem_en_o,
  output logic [`OBI_AW-1:0]                mem_addr_o,
  output logic [`OBI_DW-1:0]                mem_wdata_o,
  output logic                              mem_we_o,
  output logic [`OBI_BEW-1:0]               mem_be_o,
  input  logic [`OBI_DW-1:0]                mem_rdata_i,
  input  logic                              mem_ready_i,
  input  logic                              mem_error_i
);

  logic rvalid_q;

  // lowest index wins
  for (genvar i = 0; i < `N_MSTR; i++) begin : g_gnt
    logic [`N_MSTR-1:0] higher;
    assign higher   = (`N_MSTR'(1) << i) - `N_MSTR'(1);
    assign gnt_o[i] = mem_ready_i & req_i[i] & ~(|(req_i & higher));
  end

  assign mem_en_o = |gnt_o;

  // and-or mux of the granted payload
  always_comb begin
    mem_addr_o  = '0;
    mem_wdata_o = '0;
    mem_we_o    = 1'b0;
    mem_be_o    = '0;
    for (int i = 0; i < `N_MSTR; i++) begin
      mem_addr_o  = mem_addr_o  | (addr_i[i]  & {`OBI_AW{gnt_o[i]}});
      mem_wdata_o = mem_wdata_o | (wdata_i[i] & {`OBI_DW{gnt_o[i]}});
      mem_we_o    = mem_we_o    | (we_i[i] & gnt_o[i]);
      mem_be_o    = mem_be_o    | (be_i[i]    & {`OBI_BEW{gnt_o[i]}});
    end
  end

  // memory answers one cycle after acceptance
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= mem_en_o;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = mem_rdata_i;
  assign err_o    = mem_error_i;

  a_gnt_onehot: assert property (
    @(posedge clk_i) disable iff (!rstn_i) $onehot0(gnt_o)
  ) else $error("memory arbiter grants more than one master");

endmodule

// ==== design/obi_axi_bridge.sv ====
`timescale 1ns/1ps
`include "obi_xbar_settings.svh"

module obi_axi_bridge (
  input  logic                              clk_i,
  input  logic                              rstn_i,

  input  logic [`N_MSTR-1:0]                req_i,
  output logic [`N_MSTR-1:0]                gnt_o,
  input  logic [`N_MSTR-1:0][`OBI_AW-1:0]   addr_i,
  input  logic [`N_MSTR-1:0][`OBI_BEW-1:0]  be_i,
  input  logic [`N_MSTR-1:0][`OBI_DW-1:0]   wdata_i,
  input  logic [`N_MSTR-1:0]                we_i,
  output logic [`OBI_DW-1:0]                rdata_o,
  output logic                              rvalid_o,
  output logic                              err_o,

  output logic [`OBI_AW-1:0]                awaddr_o,
  output logic                              awvalid_o,
  input  logic                              awready_i,

  output logic [`AXI_DW-1:0]                wdata_o,
  output logic [`OBI_BEW-1:0]               wstrb_o,
  output logic                              wvalid_o,
  input  logic                              wready_i,

  input  logic [1:0]                        bresp_i,
  input  logic                              bvalid_i,

  output logic [`OBI_AW-1:0]                araddr_o,
  output logic                              arvalid_o,
  input  logic                              arready_i,

  input  logic [`AXI_DW-1:0]                rdata_i,
  input  logic [1:0]                        rresp_i,
  input  logic                              rvalid_i
);

  obi_xbar_pkg::axi_state_e state_q;

  logic [`N_MSTR-1:0]  win;
  logic [`N_MSTR-1:0]  sel_q;
  logic [`OBI_AW-1:0]  axi_addr;
  logic [`AXI_DW-1:0]  axi_wdata;
  logic [`OBI_BEW-1:0] axi_be;
  logic                axi_we;
  logic                we_q;
  logic                aw_done;
  logic                w_done;
  logic                in_acc;
  logic                acc_done;
  logic                resp_done;

  // ========================================
  // winner select and latched payload
  // ========================================

  for (genvar i = 0; i < `N_MSTR; i++) begin : g_win
    logic [`N_MSTR-1:0] higher;
    assign higher = (`N_MSTR'(1) << i) - `N_MSTR'(1);
    assign win[i] = req_i[i] & ~(|(req_i & higher));
  end

  // master holds its payload until gnt, so no copy is needed
  always_comb begin
    axi_addr  = '0;
    axi_wdata = '0;
    axi_be    = '0;
    axi_we    = 1'b0;
    for (int i = 0; i < `N_MSTR; i++) begin
      axi_addr  = axi_addr  | (addr_i[i] & {`OBI_AW{sel_q[i]}});
      axi_wdata = axi_wdata | (wdata_i[i][`AXI_DW-1:0] & {`AXI_DW{sel_q[i]}});
      axi_be    = axi_be    | (be_i[i] & {`OBI_BEW{sel_q[i]}});
      axi_we    = axi_we    | (we_i[i] & sel_q[i]);
    end
  end

  // ========================================
  // AXI channels
  // ========================================

  assign in_acc = (state_q == obi_xbar_pkg::AXI_ACC);

  assign awaddr_o  = axi_addr;
  assign awvalid_o = in_acc & axi_we & ~aw_done;
  assign wdata_o   = axi_wdata;
  assign wstrb_o   = axi_be;
  assign wvalid_o  = in_acc & axi_we & ~w_done;
  assign araddr_o  = axi_addr;
  assign arvalid_o = in_acc & ~axi_we;

  assign acc_done  = axi_we ? ((aw_done | awready_i) & (w_done | wready_i)) : arready_i;
  assign resp_done = we_q ? bvalid_i : rvalid_i;

  // grant only the latched master
  assign gnt_o    = sel_q & {`N_MSTR{in_acc & acc_done}};
  assign rvalid_o = (state_q == obi_xbar_pkg::AXI_RESP) & resp_done;
  assign err_o    = rvalid_o & (we_q ? bresp_i[1] : rresp_i[1]);
  assign rdata_o  = {{(`OBI_DW - `AXI_DW){1'b0}}, rdata_i};

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      state_q <= obi_xbar_pkg::AXI_IDLE;
      sel_q   <= '0;
      we_q    <= 1'b0;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      case (state_q)
        obi_xbar_pkg::AXI_IDLE: begin
          if (|req_i) begin
            state_q <= obi_xbar_pkg::AXI_ACC;
            sel_q   <= win;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
          end
        end
        obi_xbar_pkg::AXI_ACC: begin
          if (awvalid_o && awready_i) begin
            aw_done <= 1'b1;
          end
          if (wvalid_o && wready_i) begin
            w_done <= 1'b1;
          end
          if (acc_done) begin
            state_q <= obi_xbar_pkg::AXI_RESP;
            we_q    <= axi_we;
          end
        end
        obi_xbar_pkg::AXI_RESP: begin
          if (resp_done) begin
            state_q <= obi_xbar_pkg::AXI_IDLE;
          end
        end
        default: begin
          state_q <= obi_xbar_pkg::AXI_IDLE;
        end
      endcase
    end
  end

  a_valid_in_acc: assert property (
    @(posedge clk_i) disable iff (!rstn_i)
    (awvalid_o | wvalid_o | arvalid_o) |-> in_acc
  ) else $error("AXI valid driven outside the access state");

  // the latched master must still be holding its request when granted
  a_gnt_held: assert property (
    @(posedge clk_i) disable iff (!rstn_i)
    (|gnt_o) |-> (|(gnt_o & req_i))
  ) else $error("AXI grant to a master that dropped its request");

endmodule

// ==== design/obi_xbar.sv ====
`timescale 1ns/1ps
`include "obi_xbar_settings.svh"

module obi_xbar (
  input  logic                  clk_i,
  input  logic                  rstn_i,

  // core data port
  input  logic                  data_req_i,
  output logic                  data_gnt_o,
  input  logic [`OBI_AW-1:0]    data_addr_i,
  input  logic [`OBI_BEW-1:0]   data_be_i,
  input  logic [`OBI_DW-1:0]    data_wdata_i,
  input  logic                  data_we_i,
  output logic [`OBI_DW-1:0]    data_rdata_o,
  output logic                  data_rvalid_o,
  output logic                  data_error_o,

  // core instruction port, read only
  input  logic                  instr_req_i,
  output logic                  instr_gnt_o,
  input  logic [`OBI_AW-1:0]    instr_addr_i,
  output logic [`OBI_DW-1:0]    instr_rdata_o,
  output logic                  instr_rvalid_o,
  output logic                  instr_error_o,

  output logic                  irom_en_o,
  output logic [`OBI_AW-1:0]    irom_addr_o,
  output logic [`OBI_DW-1:0]    irom_wdata_o,
  output logic                  irom_we_o,
  output logic [`OBI_BEW-1:0]   irom_be_o,
  input  logic [`OBI_DW-1:0]    irom_rdata_i,
  input  logic                  irom_ready_i,
  input  logic                  irom_error_i,

  output logic                  dram_en_o,
  output logic [`OBI_AW-1:0]    dram_addr_o,
  output logic [`OBI_DW-1:0]    dram_wdata_o,
  output logic                  dram_we_o,
  output logic [`OBI_BEW-1:0]   dram_be_o,
  input  logic [`OBI_DW-1:0]    dram_rdata_i,
  input  logic                  dram_ready_i,
  input  logic                  dram_error_i,

  output logic [`OBI_AW-1:0]    awaddr_o,
  output logic                  awvalid_o,
  input  logic                  awready_i,
  output logic [`AXI_DW-1:0]    wdata_o,
  output logic [`OBI_BEW-1:0]   wstrb_o,
  output logic                  wvalid_o,
  input  logic                  wready_i,
  input  logic [1:0]            bresp_i,
  input  logic                  bvalid_i,
  output logic [`OBI_AW-1:0]    araddr_o,
  output logic                  arvalid_o,
  input  logic                  arready_i,
  input  logic [`AXI_DW-1:0]    rdata_i,
  input  logic [1:0]            rresp_i,
  input  logic                  rvalid_i
);

  localparam int IROM = obi_xbar_pkg::SLV_IROM;
  localparam int DRAM = obi_xbar_pkg::SLV_DRAM;
  localparam int AXI  = obi_xbar_pkg::SLV_AXI;

  // master side, indexed by slave
  logic [`N_SLV-1:0]                data_slv_req;
  logic [`N_SLV-1:0]                data_slv_gnt;
  logic [`N_SLV-1:0]                instr_slv_req;
  logic [`N_SLV-1:0]                instr_slv_gnt;
  logic [`N_SLV-1:0][`OBI_DW-1:0]   s2m_rdata;
  logic [`N_SLV-1:0]                s2m_rvalid;
  logic [`N_SLV-1:0]                s2m_err;

  // slave side, indexed by master
  logic [`N_MSTR-1:0]               irom_req;
  logic [`N_MSTR-1:0]               irom_gnt;
  logic [`N_MSTR-1:0]               dram_req;
  logic [`N_MSTR-1:0]               dram_gnt;
  logic [`N_MSTR-1:0]               axi_req;
  logic [`N_MSTR-1:0]               axi_gnt;
  logic [`N_MSTR-1:0][`OBI_AW-1:0]  m2s_addr;
  logic [`N_MSTR-1:0][`OBI_BEW-1:0] m2s_be;
  logic [`N_MSTR-1:0][`OBI_DW-1:0]  m2s_wdata;
  logic [`N_MSTR-1:0]               m2s_we;

  // ========================================
  // request and grant transpose
  // ========================================
  assign irom_req = {instr_slv_req[IROM], data_slv_req[IROM]};
  assign dram_req = {instr_slv_req[DRAM], data_slv_req[DRAM]};
  assign axi_req  = {instr_slv_req[AXI],  data_slv_req[AXI]};

  assign data_slv_gnt  = {axi_gnt[0], dram_gnt[0], irom_gnt[0]};
  assign instr_slv_gnt = {axi_gnt[1], dram_gnt[1], irom_gnt[1]};

  // instruction fetch is always a full-word read
  assign m2s_addr  = {instr_addr_i, data_addr_i};
  assign m2s_be    = {{`OBI_BEW{1'b1}}, data_be_i};
  assign m2s_wdata = {{`OBI_DW{1'b0}}, data_wdata_i};
  assign m2s_we    = {1'b0, data_we_i};

  obi_mstr_port u_data_port (
    .clk_i(clk_i), .rstn_i(rstn_i),
    .req_i(data_req_i), .gnt_o(data_gnt_o), .addr_i(data_addr_i),
    .rdata_o(data_rdata_o), .rvalid_o(data_rvalid_o), .err_o(data_error_o),
    .slv_req_o(data_slv_req), .slv_gnt_i(data_slv_gnt), .slv_rdata_i(s2m_rdata),
    .slv_rvalid_i(s2m_rvalid), .slv_err_i(s2m_err)
  );

  obi_mstr_port u_instr_port (
    .clk_i(clk_i), .rstn_i(rstn_i),
    .req_i(instr_req_i), .gnt_o(instr_gnt_o), .addr_i(instr_addr_i),
    .rdata_o(instr_rdata_o), .rvalid_o(instr_rvalid_o), .err_o(instr_error_o),
    .slv_req_o(instr_slv_req), .slv_gnt_i(instr_slv_gnt), .slv_rdata_i(s2m_rdata),
    .slv_rvalid_i(s2m_rvalid), .slv_err_i(s2m_err)
  );

  obi_mem_arb u_irom_arb (
    .clk_i(clk_i), .rstn_i(rstn_i),
    .req_i(irom_req), .gnt_o(irom_gnt), .addr_i(m2s_addr), .be_i(m2s_be),
    .wdata_i(m2s_wdata), .we_i(m2s_we),
    .rdata_o(s2m_rdata[IROM]), .rvalid_o(s2m_rvalid[IROM]), .err_o(s2m_err[IROM]),
    .mem_en_o(irom_en_o), .mem_addr_o(irom_addr_o), .mem_wdata_o(irom_wdata_o),
    .mem_we_o(irom_we_o), .mem_be_o(irom_be_o), .mem_rdata_i(irom_rdata_i),
    .mem_ready_i(irom_ready_i), .mem_error_i(irom_error_i)
  );

  obi_mem_arb u_dram_arb (
    .clk_i(clk_i), .rstn_i(rstn_i),
    .req_i(dram_req), .gnt_o(dram_gnt), .addr_i(m2s_addr), .be_i(m2s_be),
    .wdata_i(m2s_wdata), .we_i(m2s_we),
    .rdata_o(s2m_rdata[DRAM]), .rvalid_o(s2m_rvalid[DRAM]), .err_o(s2m_err[DRAM]),
    .mem_en_o(dram_en_o), .mem_addr_o(dram_addr_o), .mem_wdata_o(dram_wdata_o),
    .mem_we_o(dram_we_o), .mem_be_o(dram_be_o), .mem_rdata_i(dram_rdata_i),
    .mem_ready_i(dram_ready_i), .mem_error_i(dram_error_i)
  );

  obi_axi_bridge u_axi_bridge (
    .clk_i(clk_i), .rstn_i(rstn_i),
    .req_i(axi_req), .gnt_o(axi_gnt), .addr_i(m2s_addr), .be_i(m2s_be),
    .wdata_i(m2s_wdata), .we_i(m2s_we),
    .rdata_o(s2m_rdata[AXI]), .rvalid_o(s2m_rvalid[AXI]), .err_o(s2m_err[AXI]),
    .awaddr_o(awaddr_o), .awvalid_o(awvalid_o), .awready_i(awready_i),
    .wdata_o(wdata_o), .wstrb_o(wstrb_o), .wvalid_o(wvalid_o), .wready_i(wready_i),
    .bresp_i(bresp_i), .bvalid_i(bvalid_i),
    .araddr_o(araddr_o), .arvalid_o(arvalid_o), .arready_i(arready_i),
    .rdata_i(rdata_i), .rresp_i(rresp_i), .rvalid_i(rvalid_i)
  );

endmodule

// ==== verification/obi_xbar_tb.sv ====
`timescale 1ns/1ps
`include "obi_xbar_settings.svh"

module obi_xbar_tb;

  localparam logic [31:0] DRAM_ERR_ADDR = 32'h200F_0100;
  localparam logic [31:0] AXI_ERR_LO    = 32'h4000_0000;
  localparam logic [31:0] AXI_ERR_HI    = 32'h4000_1000;

  logic clk_i = 1'b0;
  logic rstn_i;
  logic data_req, data_gnt, data_we, data_rvalid, data_error;
  logic [31:0] data_addr;
  logic [3:0] data_be;
  logic [32:0] data_wdata, data_rdata;
  logic instr_req, instr_gnt, instr_rvalid, instr_error;
  logic [31:0] instr_addr;
  logic [32:0] instr_rdata;
  logic irom_en, irom_we, irom_ready, irom_error, dram_en, dram_we, dram_ready, dram_error;
  logic [31:0] irom_addr, dram_addr;
  logic [32:0] irom_wdata, irom_rdata, dram_wdata, dram_rdata;
  logic [3:0] irom_be, dram_be, wstrb;
  logic [31:0] awaddr, araddr, axi_wdata, axi_rdata;
  logic awvalid, awready, wvalid, wready, bvalid, arvalid, arready, rvalid;
  logic [1:0] bresp, rresp;

  integer seed = 32'hd9a6a716;
  int cycles = 0;
  int n_issued = 0;
  int n_checks = 0;
  int n_errors = 0;

  // {is_write, error, rdata}
  logic [34:0] exp_data_q[$];
  logic [34:0] exp_instr_q[$];
  logic [32:0] ram_shadow[logic [31:0]];
  logic [31:0] axi_shadow[logic [31:0]];
  logic [32:0] ram_mem[logic [31:0]];
  logic [31:0] axi_mem[logic [31:0]];

  logic [31:0] aw_addr_q, ar_addr_q, w_data_q;
  logic got_aw = 1'b0;
  logic got_w = 1'b0;
  logic got_ar = 1'b0;

  obi_xbar UUT (
    .clk_i(clk_i), .rstn_i(rstn_i),
    .data_req_i(data_req), .data_gnt_o(data_gnt), .data_addr_i(data_addr),
    .data_be_i(data_be), .data_wdata_i(data_wdata), .data_we_i(data_we),
    .data_rdata_o(data_rdata), .data_rvalid_o(data_rvalid), .data_error_o(data_error),
    .instr_req_i(instr_req), .instr_gnt_o(instr_gnt), .instr_addr_i(instr_addr),
    .instr_rdata_o(instr_rdata), .instr_rvalid_o(instr_rvalid),
    .instr_error_o(instr_error),
    .irom_en_o(irom_en), .irom_addr_o(irom_addr), .irom_wdata_o(irom_wdata),
    .irom_we_o(irom_we), .irom_be_o(irom_be), .irom_rdata_i(irom_rdata),
    .irom_ready_i(irom_ready), .irom_error_i(irom_error),
    .dram_en_o(dram_en), .dram_addr_o(dram_addr), .dram_wdata_o(dram_wdata),
    .dram_we_o(dram_we), .dram_be_o(dram_be), .dram_rdata_i(dram_rdata),
    .dram_ready_i(dram_ready), .dram_error_i(dram_error),
    .awaddr_o(awaddr), .awvalid_o(awvalid), .awready_i(awready),
    .wdata_o(axi_wdata), .wstrb_o(wstrb), .wvalid_o(wvalid), .wready_i(wready),
    .bresp_i(bresp), .bvalid_i(bvalid),
    .araddr_o(araddr), .arvalid_o(arvalid), .arready_i(arready),
    .rdata_i(axi_rdata), .rresp_i(rresp), .rvalid_i(rvalid)
  );

  initial begin
    forever #4 clk_i = ~clk_i;
  end

  // ========================================
  // reference model
  // ========================================
  function automatic logic [32:0] addr_word(input logic [31:0] a);
    return {a[3], a ^ 32'h5a5a_c3c3};
  endfunction

  function automatic bit in_irom(input logic [31:0] a);
    return a >= `IROM_START && a < `IROM_END;
  endfunction

  function automatic bit in_dram(input logic [31:0] a);
    return a >= `DRAM_START && a < `DRAM_END;
  endfunction

  function automatic bit in_axi_err(input logic [31:0] a);
    return a >= AXI_ERR_LO && a < AXI_ERR_HI;
  endfunction

  function automatic logic [34:0] expected_resp(input int m, input logic [31:0] a,
                                                input logic we);
    logic wr;
    logic err;
    logic [32:0] rd;
    logic [32:0] w;
    // instruction port only reads
    wr  = (m == 0) && we;
    err = 1'b0;
    w   = addr_word(a);
    if (in_irom(a)) begin
      rd = w;
    end else if (in_dram(a)) begin
      err = (a == DRAM_ERR_ADDR);
      rd  = ram_shadow.exists(a) ? ram_shadow[a] : w;
    end else begin
      err = in_axi_err(a);
      rd  = axi_shadow.exists(a) ? {1'b0, axi_shadow[a]} : {1'b0, w[31:0]};
    end
    return {wr, err, rd};
  endfunction

  // ========================================
  // slave models
  // ========================================
  always @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      irom_rdata <= '0;
      irom_error <= 1'b0;
      dram_rdata <= '0;
      dram_error <= 1'b0;
    end else begin
      if (irom_en && irom_ready) begin
        irom_rdata <= addr_word(irom_addr);
        irom_error <= 1'b0;
        // only full-word reads ever reach the ROM
        check_val("rom we", {32'd0, irom_we}, 33'd0);
        check_val("rom be", {29'd0, irom_be}, 33'hF);
        check_val("rom wdata", irom_wdata, 33'd0);
      end
      if (dram_en && dram_ready) begin
        check_val("ram be", {29'd0, dram_be}, 33'hF);
        if (dram_we) ram_mem[dram_addr] = dram_wdata;
        dram_rdata <= ram_mem.exists(dram_addr) ? ram_mem[dram_addr] : addr_word(dram_addr);
        dram_error <= (dram_addr == DRAM_ERR_ADDR);
      end
    end
  end

  // AXI handshakes seen at the rising edge
  always @(posedge clk_i) begin
    if (awvalid && awready) begin
      aw_addr_q = awaddr;
      got_aw = 1'b1;
    end
    if (wvalid && wready) begin
      check_val("axi wstrb", {29'd0, wstrb}, 33'hF);
      w_data_q = axi_wdata;
      got_w = 1'b1;
    end
    if (arvalid && arready) begin
      ar_addr_q = araddr;
      got_ar = 1'b1;
    end
  end

  // random readies and delayed responses
  always @(negedge clk_i) begin
    logic [32:0] w;
    irom_ready = ($random(seed) & 3) != 0;
    dram_ready = ($random(seed) & 3) != 0;
    awready    = ($random(seed) & 1) != 0;
    wready     = ($random(seed) & 1) != 0;
    arready    = ($random(seed) & 1) != 0;
    if (bvalid) begin
      bvalid = 1'b0;
    end else if (got_aw && got_w && (($random(seed) & 3) == 0)) begin
      axi_mem[aw_addr_q] = w_data_q;
      bresp  = in_axi_err(aw_addr_q) ? 2'b10 : 2'b00;
      bvalid = 1'b1;
      got_aw = 1'b0;
      got_w  = 1'b0;
    end
    if (rvalid) begin
      rvalid = 1'b0;
    end else if (got_ar && (($random(seed) & 3) == 0)) begin
      w = addr_word(ar_addr_q);
      axi_rdata = axi_mem.exists(ar_addr_q) ? axi_mem[ar_addr_q] : w[31:0];
      rresp  = in_axi_err(ar_addr_q) ? 2'b10 : 2'b00;
      rvalid = 1'b1;
      got_ar = 1'b0;
    end
  end

  // ========================================
  // checking
  // ========================================
  task automatic check_val(input string what, input logic [32:0] got, input logic [32:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_resp(input string port, input logic [34:0] e,
                              input logic [32:0] rd, input logic err);
    check_val({port, " error"}, {32'd0, err}, {32'd0, e[33]});
    if (!e[34]) check_val({port, " rdata"}, rd, e[32:0]);
  endtask

  always @(posedge clk_i) begin
    logic [34:0] e;
    if (rstn_i && data_rvalid) begin
      if (exp_data_q.size() == 0) begin
        n_errors++;
        $display("unexpected response on the data port at %0t", $time);
      end else begin
        e = exp_data_q.pop_front();
        compare_resp("data", e, data_rdata, data_error);
      end
    end
    if (rstn_i && instr_rvalid) begin
      if (exp_instr_q.size() == 0) begin
        n_errors++;
        $display("unexpected response on the instruction port at %0t", $time);
      end else begin
        e = exp_instr_q.pop_front();
        compare_resp("instr", e, instr_rdata, instr_error);
      end
    end
  end

  // watchdog grows with the number of issued transfers
  always @(posedge clk_i) begin
    cycles++;
    if (cycles > 20 * n_issued + 200) begin
      $display("timeout: responses still missing after %0d cycles", cycles);
      $display("checks: %0d, errors: %0d", n_checks, n_errors);
      $display("Some tests failed");
      $finish;
    end
  end

  // ========================================
  // stimulus
  // ========================================
  task automatic issue(input int m, input logic [31:0] a, input logic we,
                       input logic [32:0] wd, output time gtime);
    logic [34:0] e;
    @(negedge clk_i);
    if (m == 0) begin
      data_req   = 1'b1;
      data_addr  = a;
      data_we    = we;
      data_wdata = wd;
      data_be    = 4'hF;
    end else begin
      instr_req  = 1'b1;
      instr_addr = a;
    end
    n_issued++;
    do @(posedge clk_i); while (!((m == 0) ? data_gnt : instr_gnt));
    gtime = $time;
    e = expected_resp(m, a, we);
    if (m == 0) begin
      if (we && in_dram(a)) ram_shadow[a] = wd;
      else if (we && !in_irom(a)) axi_shadow[a] = wd[31:0];
      exp_data_q.push_back(e);
    end else begin
      exp_instr_q.push_back(e);
    end
  endtask

  task automatic release_reqs();
    @(negedge clk_i);
    data_req  = 1'b0;
    data_we   = 1'b0;
    instr_req = 1'b0;
  endtask

  initial begin
    time t0;
    time t1;
    logic [31:0] a;
    data_req   = 1'b0;
    data_addr  = '0;
    data_be    = '0;
    data_wdata = '0;
    data_we    = 1'b0;
    instr_req  = 1'b0;
    instr_addr = '0;
    irom_ready = 1'b0;
    dram_ready = 1'b0;
    awready    = 1'b0;
    wready     = 1'b0;
    arready    = 1'b0;
    bvalid     = 1'b0;
    bresp      = '0;
    rvalid     = 1'b0;
    rresp      = '0;
    axi_rdata  = '0;
    rstn_i = 1'b0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rstn_i = 1'b1;

    issue(0, 32'h2000_0010, 0, '0, t0);
    issue(0, 32'h200F_0020, 0, '0, t0);
    issue(0, 32'h3000_0040, 0, '0, t0);
    // write then read back, AXI drops the tag bit
    issue(0, 32'h200F_0040, 1, 33'h1_dead_beef, t0);
    issue(0, 32'h200F_0040, 0, '0, t0);
    issue(0, 32'h3000_0080, 1, 33'h1_cafe_f00d, t0);
    issue(0, 32'h3000_0080, 0, '0, t0);
    release_reqs();

    // data port idle so both ROM requests meet in the same cycle
    while (exp_data_q.size() != 0) @(posedge clk_i);
    fork
      begin
        issue(0, 32'h2000_0100, 0, '0, t0);
        @(negedge clk_i);
        data_req = 1'b0;
      end
      begin
        issue(1, 32'h2000_0204, 0, '0, t1);
        @(negedge clk_i);
        instr_req = 1'b0;
      end
    join
    check_val("ROM grant order", {32'd0, t0 <= t1}, 33'd1);
    // random draws stay off the falling edge used by the slave models
    @(posedge clk_i);

    for (int i = 0; i < 8; i++) begin
      a = 32'h4000_0000 + ($random(seed) & 32'h1FFC);
      issue(0, a, i[0], {1'b0, $random(seed)}, t0);
    end
    issue(0, DRAM_ERR_ADDR, 0, '0, t0);
    issue(0, 32'h2000_0300, 0, '0, t0);
    release_reqs();

    for (int i = 0; i < 6; i++) begin
      a = i[0] ? (32'h5000_0000 + i * 4) : (32'h2000_0400 + i * 4);
      issue(1, a, 0, '0, t1);
    end
    release_reqs();

    while (exp_data_q.size() != 0 || exp_instr_q.size() != 0) @(posedge clk_i);
    repeat (5) @(posedge clk_i);
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== obi_xbar.f ====
+incdir+design
design/obi_xbar_pkg.sv
design/obi_mstr_port.sv
design/obi_mem_arb.sv
design/obi_axi_bridge.sv
design/obi_xbar.sv
verification/obi_xbar_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the crossbar testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module obi_xbar_tb -f obi_xbar.f -o sim_obi_xbar
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out="$(./obj_dir/sim_obi_xbar)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "All tests passed"; then
  exit 0
fi
exit 1
